// File: hdl/plic_pkg.sv
package plic_pkg;

    // sizes
    localparam int num_sources = 16;
    localparam int id_width    = 4;   // clog2 of num_sources
    localparam int addr_width  = 12;
    localparam int data_width  = 32;
    localparam int pri_width   = 8;   // one byte of priority per source

    // address map, byte addresses
    localparam logic [addr_width-1:0] addr_int_en   = 12'h000;
    localparam logic [addr_width-1:0] addr_int_pri  = 12'h100; // 16 bytes, 4 words
    localparam logic [addr_width-1:0] addr_claim_id = 12'h200;
    localparam logic [addr_width-1:0] addr_mvec     = 12'h204;
    localparam logic [addr_width-1:0] addr_marg     = 12'h208;
    localparam logic [addr_width-1:0] addr_vectable = 12'h400; // one word per source
    localparam logic [addr_width-1:0] addr_objtable = 12'h800; // one word per source

    // low address bits covered by a block, used in range decode
    localparam int pri_span_lsb = id_width;     // 16 priority bytes
    localparam int tbl_span_lsb = id_width + 2; // 16 table words

    // bus data word, seen whole or as four priority bytes
    typedef union packed {
        logic [data_width-1:0]   raw;
        logic [3:0][pri_width-1:0] pri; // byte 0 in the low bits
    } plic_word_u;

    // one write into the vector or object table
    typedef struct packed {
        logic                  en;
        logic                  sel;   // 0 vector, 1 object
        logic [id_width-1:0]   index;
        logic [data_width-1:0] data;
    } plic_tbl_wr_t;

    // current arbitration result
    typedef struct packed {
        logic                valid;
        logic [id_width-1:0] id;
    } plic_claim_t;

endpackage

// File: hdl/plic_csr.sv
`timescale 1ns/1ps

module plic_csr (
    input  logic                                   clk,
    input  logic                                   rst_n,

    // write port
    input  logic [plic_pkg::addr_width-1:0]        waddr,
    input  logic [plic_pkg::data_width-1:0]        wdata,
    input  logic [3:0]                             wstrb,
    input  logic                                   wen,

    // read port
    input  logic [plic_pkg::addr_width-1:0]        raddr,
    output logic [plic_pkg::data_width-1:0]        rdata,

    // to the arbiter
    output logic [plic_pkg::num_sources-1:0]       int_en,
    output logic [plic_pkg::num_sources-1:0][plic_pkg::pri_width-1:0] int_pri,
    input  plic_pkg::plic_claim_t                  claim,

    // table side
    output plic_pkg::plic_tbl_wr_t                 tbl_wr,
    output logic                                   tbl_rd_sel,
    output logic [plic_pkg::id_width-1:0]          tbl_rd_index,
    input  logic [plic_pkg::data_width-1:0]        tbl_rdata,
    input  logic [plic_pkg::data_width-1:0]        mvec,
    input  logic [plic_pkg::data_width-1:0]        marg
);

    import plic_pkg::*;

    plic_word_u wr_word;
    plic_word_u rd_word;

    logic en_wr_hit;
    logic pri_wr_hit;
    logic vec_wr_hit;
    logic obj_wr_hit;

    logic en_rd_hit;
    logic pri_rd_hit;
    logic vec_rd_hit;
    logic obj_rd_hit;

    assign wr_word = wdata;

    // write decode
    assign en_wr_hit  = (waddr == addr_int_en);
    assign pri_wr_hit = (waddr[addr_width-1:pri_span_lsb] ==
                         addr_int_pri[addr_width-1:pri_span_lsb]);
    assign vec_wr_hit = (waddr[addr_width-1:tbl_span_lsb] ==
                         addr_vectable[addr_width-1:tbl_span_lsb]);
    assign obj_wr_hit = (waddr[addr_width-1:tbl_span_lsb] ==
                         addr_objtable[addr_width-1:tbl_span_lsb]);

    // read decode
    assign en_rd_hit  = (raddr == addr_int_en);
    assign pri_rd_hit = (raddr[addr_width-1:pri_span_lsb] ==
                         addr_int_pri[addr_width-1:pri_span_lsb]);
    assign vec_rd_hit = (raddr[addr_width-1:tbl_span_lsb] ==
                         addr_vectable[addr_width-1:tbl_span_lsb]);
    assign obj_rd_hit = (raddr[addr_width-1:tbl_span_lsb] ==
                         addr_objtable[addr_width-1:tbl_span_lsb]);

    // enable and priority registers
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            int_en  <= '0;
            int_pri <= '0;
        end else if (wen) begin
            if (en_wr_hit) begin
                for (int b = 0; b < num_sources / 8; b++) begin
                    if (wstrb[b])
                        int_en[b*8 +: 8] <= wr_word.raw[b*8 +: 8];
                end
            end else if (pri_wr_hit) begin
                // word index from waddr[3:2], byte lane from the strobe
                for (int b = 0; b < 4; b++) begin
                    if (wstrb[b])
                        int_pri[{waddr[3:2], 2'(b)}] <= wr_word.pri[b];
                end
            end
        end
    end

    // table writes go straight to the table block
    always_comb begin
        tbl_wr.en    = wen && (vec_wr_hit || obj_wr_hit);
        tbl_wr.sel   = obj_wr_hit;
        tbl_wr.index = waddr[tbl_span_lsb-1:2];
        tbl_wr.data  = wdata;
    end

    assign tbl_rd_sel   = obj_rd_hit;
    assign tbl_rd_index = raddr[tbl_span_lsb-1:2];

    // enable and priority read word
    always_comb begin
        rd_word = '0;
        if (pri_rd_hit) begin
            for (int b = 0; b < 4; b++)
                rd_word.pri[b] = int_pri[{raddr[3:2], 2'(b)}];
        end else if (en_rd_hit) begin
            rd_word.raw[num_sources-1:0] = int_en;
        end
    end

    // read mux, unmapped reads return zero
    always_comb begin
        rdata = '0;
        if (en_rd_hit || pri_rd_hit)
            rdata = rd_word.raw;
        else if (raddr == addr_claim_id)
            rdata = {{(data_width-id_width){1'b0}}, claim.id};
        else if (raddr == addr_mvec)
            rdata = mvec;
        else if (raddr == addr_marg)
            rdata = marg;
        else if (vec_rd_hit || obj_rd_hit)
            rdata = tbl_rdata;   // sel already picks the table
    end

endmodule

// File: hdl/plic_priority_arbiter.sv
`timescale 1ns/1ps

module plic_priority_arbiter (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic [plic_pkg::num_sources-1:0]       irq_sources,
    input  logic [plic_pkg::num_sources-1:0]       int_en,
    input  logic [plic_pkg::num_sources-1:0][plic_pkg::pri_width-1:0] int_pri,
    output plic_pkg::plic_claim_t                  claim
);

    import plic_pkg::*;

    // one contender in the compare tree
    typedef struct packed {
        logic                 valid;
        logic [pri_width-1:0] pri;
        logic [id_width-1:0]  id;
    } cand_t;

    logic [num_sources-1:0] masked_q;   // stage 0
    cand_t [3:0]            grp_d;
    cand_t [3:0]            grp_q;      // stage 1, four groups of four
    cand_t                  final_d;
    cand_t                  final_q;    // stage 2

    // a is always the lower id, so it keeps ties
    function automatic cand_t pick(input cand_t a, input cand_t b);
        if (b.valid && (!a.valid || (b.pri > a.pri)))
            return b;
        return a;
    endfunction

    // group stage, priorities sampled here
    always_comb begin
        cand_t c;
        for (int g = 0; g < 4; g++) begin
            grp_d[g] = '0;
            for (int k = 0; k < 4; k++) begin
                c.valid = masked_q[g*4 + k];
                c.pri   = int_pri[g*4 + k];
                c.id    = id_width'(g*4 + k);
                if (k == 0)
                    grp_d[g] = c;
                else
                    grp_d[g] = pick(grp_d[g], c);
            end
        end
    end

    // final stage over the four group winners
    always_comb begin
        final_d = grp_q[0];
        for (int g = 1; g < 4; g++)
            final_d = pick(final_d, grp_q[g]);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            masked_q <= '0;
            grp_q    <= '0;
            final_q  <= '0;
            claim    <= '0;
        end else begin
            masked_q    <= irq_sources & int_en;
            grp_q       <= grp_d;
            final_q     <= final_d;
            claim.valid <= final_q.valid;
            claim.id    <= final_q.id;  // id 0 when nothing pending
        end
    end

endmodule

// File: hdl/plic_vector_table.sv
`timescale 1ns/1ps

module plic_vector_table (
    input  logic                             clk,
    input  logic                             rst_n,

    // bus side
    input  plic_pkg::plic_tbl_wr_t           tbl_wr,
    input  logic                             tbl_rd_sel,
    input  logic [plic_pkg::id_width-1:0]    tbl_rd_index,
    output logic [plic_pkg::data_width-1:0]  tbl_rdata,

    // claim capture
    input  plic_pkg::plic_claim_t            claim,
    output logic [plic_pkg::data_width-1:0]  mvec,
    output logic [plic_pkg::data_width-1:0]  marg
);

    import plic_pkg::*;

    logic [data_width-1:0] vec_tbl [num_sources];  // entry addresses
    logic [data_width-1:0] obj_tbl [num_sources];  // object arguments

    // table writes, both tables clear on reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < num_sources; i++) begin
                vec_tbl[i] <= '0;
                obj_tbl[i] <= '0;
            end
        end else if (tbl_wr.en) begin
            if (tbl_wr.sel)
                obj_tbl[tbl_wr.index] <= tbl_wr.data;
            else
                vec_tbl[tbl_wr.index] <= tbl_wr.data;
        end
    end

    // bus read port
    assign tbl_rdata = tbl_rd_sel ? obj_tbl[tbl_rd_index] : vec_tbl[tbl_rd_index];

    // MVEC / MARG follow the winner while a claim is up, hold otherwise
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mvec <= '0;
            marg <= '0;
        end else if (claim.valid) begin
            mvec <= vec_tbl[claim.id];
            marg <= obj_tbl[claim.id];
        end
    end

endmodule

// File: hdl/plic.sv
`timescale 1ns/1ps

module plic (
    input  logic                                clk,
    input  logic                                rst_n,

    // write port
    input  logic [plic_pkg::addr_width-1:0]     waddr,
    input  logic [plic_pkg::data_width-1:0]     wdata,
    input  logic [3:0]                          wstrb,
    input  logic                                wen,

    // read port
    input  logic [plic_pkg::addr_width-1:0]     raddr,
    output logic [plic_pkg::data_width-1:0]     rdata,

    input  logic [plic_pkg::num_sources-1:0]    irq_sources,
    output logic                                irq_valid
);

    import plic_pkg::*;

    logic [num_sources-1:0]                int_en;
    logic [num_sources-1:0][pri_width-1:0] int_pri;
    plic_claim_t                           claim;
    plic_tbl_wr_t                          tbl_wr;
    logic                                  tbl_rd_sel;
    logic [id_width-1:0]                   tbl_rd_index;
    logic [data_width-1:0]                 tbl_rdata;
    logic [data_width-1:0]                 mvec;
    logic [data_width-1:0]                 marg;

    plic_csr u_csr (
        .clk          (clk),
        .rst_n        (rst_n),
        .waddr        (waddr),
        .wdata        (wdata),
        .wstrb        (wstrb),
        .wen          (wen),
        .raddr        (raddr),
        .rdata        (rdata),
        .int_en       (int_en),
        .int_pri      (int_pri),
        .claim        (claim),
        .tbl_wr       (tbl_wr),
        .tbl_rd_sel   (tbl_rd_sel),
        .tbl_rd_index (tbl_rd_index),
        .tbl_rdata    (tbl_rdata),
        .mvec         (mvec),
        .marg         (marg)
    );

    plic_priority_arbiter u_arbiter (
        .clk          (clk),
        .rst_n        (rst_n),
        .irq_sources  (irq_sources),
        .int_en       (int_en),
        .int_pri      (int_pri),
        .claim        (claim)
    );

    plic_vector_table u_vector_table (
        .clk          (clk),
        .rst_n        (rst_n),
        .tbl_wr       (tbl_wr),
        .tbl_rd_sel   (tbl_rd_sel),
        .tbl_rd_index (tbl_rd_index),
        .tbl_rdata    (tbl_rdata),
        .claim        (claim),
        .mvec         (mvec),
        .marg         (marg)
    );

    assign irq_valid = claim.valid;

endmodule

// File: tests/plic_properties.sv
`timescale 1ns/1ps

module plic_properties #(
    parameter bit arb_side = 1'b1   // claim checks on the arbiter, mvec check on the table
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  plic_pkg::plic_claim_t             claim,
    input  logic [plic_pkg::num_sources-1:0]  pending,  // sources and enables
    input  logic [plic_pkg::data_width-1:0]   mvec
);

    if (arb_side) begin : g_arb
        // claim is cleared as long as reset holds
        no_claim_in_reset: assert property (@(posedge clk) !rst_n |-> !claim.valid)
            else $error("claim valid while reset is asserted");

        // pending seen at E shows up in claim sampled at E+4
        idle_gives_no_claim: assert property (@(posedge clk) disable iff (!rst_n)
            $past(pending, 4) == '0 |-> !claim.valid)
            else $error("claim valid with no enabled source pending");
    end else begin : g_tbl
        mvec_holds_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
            !claim.valid |=> $stable(mvec))
            else $error("mvec changed while claim was invalid");
    end

endmodule

bind plic_priority_arbiter plic_properties #(.arb_side(1'b1)) u_props (
    .clk     (clk),
    .rst_n   (rst_n),
    .claim   (claim),
    .pending (irq_sources & int_en),
    .mvec    ('0)        // no capture register in the arbiter
);

bind plic_vector_table plic_properties #(.arb_side(1'b0)) u_props (
    .clk     (clk),
    .rst_n   (rst_n),
    .claim   (claim),
    .pending ('1),       // sources are not visible here
    .mvec    (mvec)
);

// File: tests/tb_plic.sv
`timescale 1ns/1ps

module tb_plic;

    import plic_pkg::*;

    localparam int clk_period    = 100;
    localparam int drive_delay   = 5;
    localparam int reset_cycles  = 16;
    localparam int settle_cycles = 4;   // sources to claim latency
    localparam int wait_limit    = 20;
    localparam int num_tests     = 6;

    localparam logic [2:0] op_write = 3'd0;
    localparam logic [2:0] op_read  = 3'd1;  // compare rdata with exp
    localparam logic [2:0] op_capt  = 3'd2;  // compare MVEC/MARG with the captured copy
    localparam logic [2:0] op_src   = 3'd3;  // drive sources, let the claim settle

    typedef struct packed {
        logic [2:0]             op;
        logic [2:0]             test;
        logic [addr_width-1:0]  addr;
        logic [data_width-1:0]  data;
        logic [3:0]             strb;
        logic [num_sources-1:0] src;
        logic [data_width-1:0]  exp;
    } stim_t;

    logic                   clk;
    logic                   rst_n;
    logic [addr_width-1:0]  waddr;
    logic [data_width-1:0]  wdata;
    logic [3:0]             wstrb;
    logic                   wen;
    logic [addr_width-1:0]  raddr;
    logic [data_width-1:0]  rdata;
    logic [num_sources-1:0] irq_sources;
    logic                   irq_valid;

    stim_t stim[$];
    int    build_test;
    int    cur_test;
    int    errors;
    int    test_errors [num_tests];
    string test_names  [num_tests];

    // software view of the controller, kept by the testbench
    logic [num_sources-1:0] en_model;
    logic [7:0]             pri_model [num_sources];
    logic [data_width-1:0]  vec_model [num_sources];
    logic [data_width-1:0]  obj_model [num_sources];
    logic [data_width-1:0]  mvec_model;
    logic [data_width-1:0]  marg_model;

    plic UUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .waddr       (waddr),
        .wdata       (wdata),
        .wstrb       (wstrb),
        .wen         (wen),
        .raddr       (raddr),
        .rdata       (rdata),
        .irq_sources (irq_sources),
        .irq_valid   (irq_valid)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    task automatic check_value(input logic [data_width-1:0] actual,
                               input logic [data_width-1:0] expected, input string msg);
        if (actual !== expected) begin
            $display("MISMATCH at %0t: %s, got %h expected %h", $time, msg, actual, expected);
            errors++;
            test_errors[cur_test]++;
        end
    endtask

    task automatic add_step(input logic [2:0] op, input logic [addr_width-1:0] addr,
                            input logic [data_width-1:0] data, input logic [3:0] strb,
                            input logic [num_sources-1:0] src,
                            input logic [data_width-1:0] exp);
        stim_t s;
        s.op   = op;
        s.test = 3'(build_test);
        s.addr = addr;
        s.data = data;
        s.strb = strb;
        s.src  = src;
        s.exp  = exp;
        stim.push_back(s);
    endtask

    task automatic bus_write(input logic [addr_width-1:0] addr,
                             input logic [data_width-1:0] data, input logic [3:0] strb);
        @(posedge clk);
        #drive_delay;
        waddr = addr;
        wdata = data;
        wstrb = strb;
        wen   = 1'b1;
        @(posedge clk);
        #drive_delay;
        wen = 1'b0;
    endtask

    task automatic bus_read(input logic [addr_width-1:0] addr,
                            output logic [data_width-1:0] data);
        @(posedge clk);
        #drive_delay;
        raddr = addr;
        #(clk_period / 2 - drive_delay);  // mid cycle, rdata settled
        data = rdata;
    endtask

    // byte rule: only strobed bytes change, tables take the whole word
    task automatic update_model(input logic [addr_width-1:0] addr,
                                input logic [data_width-1:0] data, input logic [3:0] strb);
        int w;
        w = int'(addr[3:2]);
        if (addr == addr_int_en) begin
            for (int b = 0; b < 2; b++)
                if (strb[b]) en_model[b*8 +: 8] = data[b*8 +: 8];
        end else if (addr >= addr_int_pri && addr < addr_int_pri + 12'h010) begin
            for (int b = 0; b < 4; b++)
                if (strb[b]) pri_model[w*4 + b] = data[b*8 +: 8];
        end else if (addr >= addr_vectable && addr < addr_vectable + 12'h040) begin
            vec_model[addr[5:2]] = data;
        end else if (addr >= addr_objtable && addr < addr_objtable + 12'h040) begin
            obj_model[addr[5:2]] = data;
        end
    endtask

    // highest priority wins, lower id on a tie, priority 0 still pending
    function automatic plic_claim_t expected_claim(input logic [num_sources-1:0] src);
        plic_claim_t c;
        logic [7:0]  best_pri;
        c        = '0;
        best_pri = '0;
        for (int i = 0; i < num_sources; i++) begin
            if (src[i] && en_model[i] && (!c.valid || pri_model[i] > best_pri)) begin
                c.valid  = 1'b1;
                c.id     = id_width'(i);
                best_pri = pri_model[i];
            end
        end
        return c;
    endfunction

    task automatic settle_claim(input logic [num_sources-1:0] src);
        plic_claim_t           want;
        logic [data_width-1:0] id_word;
        int                    cyc;
        want = expected_claim(src);
        @(posedge clk);
        #drive_delay;
        irq_sources = src;
        cyc = 0;
        // full pipeline depth first, then until irq_valid agrees
        while (cyc < settle_cycles || (irq_valid !== want.valid && cyc < wait_limit)) begin
            @(posedge clk);
            #(clk_period / 2);
            cyc++;
        end
        if (irq_valid !== want.valid) begin
            $display("timeout: irq_valid did not reach %0b within %0d cycles, sources %h",
                     want.valid, wait_limit, src);
            errors++;
            test_errors[cur_test]++;
        end else if (want.valid) begin
            bus_read(addr_claim_id, id_word);
            check_value(id_word, {{(data_width-id_width){1'b0}}, want.id},
                        $sformatf("claim id for sources %h", src));
            mvec_model = vec_model[want.id];  // captured on the edge after valid
            marg_model = obj_model[want.id];
        end
    endtask

    task automatic build_steps();
        logic [data_width-1:0] rnd_vec [num_sources];
        logic [data_width-1:0] rnd_obj [num_sources];
        build_test = 0;  // reset values
        add_step(op_src, '0, '0, '0, 16'h0000, '0);
        add_step(op_read, addr_int_en, '0, '0, '0, '0);
        for (int k = 0; k < 4; k++)
            add_step(op_read, addr_int_pri + 12'(k*4), '0, '0, '0, '0);
        add_step(op_read, addr_claim_id, '0, '0, '0, '0);
        add_step(op_read, addr_mvec, '0, '0, '0, '0);
        add_step(op_read, addr_marg, '0, '0, '0, '0);
        for (int k = 0; k < num_sources; k++) begin
            add_step(op_read, addr_vectable + 12'(k*4), '0, '0, '0, '0);
            add_step(op_read, addr_objtable + 12'(k*4), '0, '0, '0, '0);
        end
        build_test = 1;  // strobes and unmapped space
        add_step(op_write, addr_int_en, 32'hFFFF_FFFF, 4'b0001, '0, '0);
        add_step(op_read,  addr_int_en, '0, '0, '0, 32'h0000_00FF);
        add_step(op_write, addr_int_en, 32'h0000_5A00, 4'b0010, '0, '0);
        add_step(op_read,  addr_int_en, '0, '0, '0, 32'h0000_5AFF);
        add_step(op_write, addr_int_en, 32'hFFFF_0000, 4'b1100, '0, '0);
        add_step(op_read,  addr_int_en, '0, '0, '0, 32'h0000_5AFF);
        add_step(op_write, 12'h104, 32'h4433_2211, 4'b0101, '0, '0);
        add_step(op_read,  12'h104, '0, '0, '0, 32'h0033_0011);
        add_step(op_write, 12'h104, 32'hAABB_CCDD, 4'b1010, '0, '0);
        add_step(op_read,  12'h104, '0, '0, '0, 32'hAA33_CC11);
        add_step(op_write, 12'h10C, 32'h0403_0201, 4'b1111, '0, '0);
        add_step(op_read,  12'h10C, '0, '0, '0, 32'h0403_0201);
        add_step(op_read,  12'h004, '0, '0, '0, '0);
        add_step(op_read,  12'h110, '0, '0, '0, '0);
        add_step(op_read,  12'h20C, '0, '0, '0, '0);
        add_step(op_read,  12'h300, '0, '0, '0, '0);
        add_step(op_read,  12'h440, '0, '0, '0, '0);
        add_step(op_read,  12'h840, '0, '0, '0, '0);
        add_step(op_read,  12'hFFC, '0, '0, '0, '0);
        build_test = 2;  // table contents
        for (int k = 0; k < num_sources; k++) begin
            rnd_vec[k] = $urandom;
            rnd_obj[k] = $urandom;
            add_step(op_write, addr_vectable + 12'(k*4), rnd_vec[k], 4'b1111, '0, '0);
            add_step(op_write, addr_objtable + 12'(k*4), rnd_obj[k], 4'b1111, '0, '0);
        end
        for (int k = 0; k < num_sources; k++) begin
            add_step(op_read, addr_vectable + 12'(k*4), '0, '0, '0, rnd_vec[k]);
            add_step(op_read, addr_objtable + 12'(k*4), '0, '0, '0, rnd_obj[k]);
        end
        build_test = 3;  // winner rule
        add_step(op_write, 12'h100, 32'h0302_0100, 4'b1111, '0, '0);
        add_step(op_write, 12'h104, 32'h0005_0505, 4'b1111, '0, '0);
        add_step(op_write, 12'h108, 32'h0701_0107, 4'b1111, '0, '0);
        add_step(op_write, 12'h10C, 32'h0000_0000, 4'b1111, '0, '0);
        add_step(op_write, addr_int_en, 32'h0000_FFFF, 4'b0011, '0, '0);
        add_step(op_src, '0, '0, '0, 16'h0001, '0);
        add_step(op_src, '0, '0, '0, 16'h000F, '0);
        add_step(op_src, '0, '0, '0, 16'h0070, '0);
        add_step(op_src, '0, '0, '0, 16'h0F7F, '0);
        add_step(op_src, '0, '0, '0, 16'h0E00, '0);
        add_step(op_src, '0, '0, '0, 16'hF000, '0);
        add_step(op_write, addr_int_en, 32'h0000_00FF, 4'b0011, '0, '0);
        add_step(op_src, '0, '0, '0, 16'hFF00, '0);
        add_step(op_src, '0, '0, '0, 16'hFF80, '0);
        add_step(op_src, '0, '0, '0, 16'h0000, '0);
        build_test = 4;  // MVEC and MARG capture
        add_step(op_write, addr_int_en, 32'h0000_FFFF, 4'b0011, '0, '0);
        add_step(op_src,  '0, '0, '0, 16'h0800, '0);
        add_step(op_capt, addr_mvec, '0, '0, '0, '0);
        add_step(op_capt, addr_marg, '0, '0, '0, '0);
        add_step(op_src,  '0, '0, '0, 16'h0000, '0);
        add_step(op_capt, addr_mvec, '0, '0, '0, '0);
        add_step(op_capt, addr_marg, '0, '0, '0, '0);
        add_step(op_src,  '0, '0, '0, 16'h0004, '0);
        add_step(op_capt, addr_mvec, '0, '0, '0, '0);
        add_step(op_capt, addr_marg, '0, '0, '0, '0);
        build_test = 5;  // priority change, sources held
        add_step(op_src,   '0, '0, '0, 16'h0101, '0);
        add_step(op_write, 12'h100, 32'h0000_0009, 4'b0001, '0, '0);
        add_step(op_src,   '0, '0, '0, 16'h0101, '0);
        add_step(op_capt,  addr_mvec, '0, '0, '0, '0);
    endtask

    initial begin
        stim_t                 s;
        logic [data_width-1:0] got;
        int                    failed;
        void'($urandom(75782));
        waddr       = '0;
        wdata       = '0;
        wstrb       = '0;
        wen         = 1'b0;
        raddr       = '0;
        irq_sources = '0;
        en_model    = '0;
        mvec_model  = '0;
        marg_model  = '0;
        for (int i = 0; i < num_sources; i++) begin
            pri_model[i] = '0;
            vec_model[i] = '0;
            obj_model[i] = '0;
        end
        for (int t = 0; t < num_tests; t++)
            test_errors[t] = 0;
        test_names = '{"reset values", "strobes and unmapped", "table readback",
                       "winner rule", "mvec marg capture", "priority change"};
        errors = 0;
        failed = 0;
        build_steps();

        rst_n = 1'b1;
        #1 rst_n = 1'b0;  // clean falling edge for the async reset
        repeat (reset_cycles) @(posedge clk);
        #drive_delay;
        rst_n = 1'b1;

        for (int i = 0; i < stim.size(); i++) begin
            s        = stim[i];
            cur_test = int'(s.test);
            case (s.op)
                op_write: begin
                    bus_write(s.addr, s.data, s.strb);
                    update_model(s.addr, s.data, s.strb);
                end
                op_read: begin
                    bus_read(s.addr, got);
                    check_value(got, s.exp, $sformatf("read at %h", s.addr));
                end
                op_capt: begin
                    bus_read(s.addr, got);
                    check_value(got, (s.addr == addr_mvec) ? mvec_model : marg_model,
                                $sformatf("captured word at %h", s.addr));
                end
                default: settle_claim(s.src);
            endcase
            if (i == stim.size() - 1 || stim[i+1].test != s.test) begin
                $display("test %0d %s: %s", cur_test + 1, test_names[cur_test],
                         (test_errors[cur_test] == 0) ? "ok" : "errors found");
                if (test_errors[cur_test] != 0)
                    failed++;
            end
        end

        $display("%0d of %0d tests failed, %0d errors", failed, num_tests, errors);
        if (errors == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

// File: verilog.f
hdl/plic_pkg.sv
hdl/plic_csr.sv
hdl/plic_priority_arbiter.sv
hdl/plic_vector_table.sv
hdl/plic.sv
tests/plic_properties.sv
tests/tb_plic.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_plic
FILELIST = verilog.f

OBJ_DIR  = obj_dir
SIM_BIN  = $(OBJ_DIR)/V$(TOP)
SOURCES  = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "ALL TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)
